// ==== rtl/regCore_cfg.svh ====
//********************
// Register ids, SR bit positions and data width of the register core
// Included by the package and by every RTL file that uses these values
//********************
`ifndef REG_CORE_CFG_SVH
`define REG_CORE_CFG_SVH

`define REG_WIDTH		64

// Inactive bank R0..R7 sits at ids 32..39
`define REG_ID_BANKB	7'd32

`define REG_ID_SR		7'd40
`define REG_ID_VBR		7'd41
`define REG_ID_GBR		7'd42
`define REG_ID_SPC		7'd43
`define REG_ID_SSR		7'd44

`define REG_ID_IMM		7'd126
`define REG_ID_ZZR		7'd127

// Selects which physical bank serves R0..R7
`define SR_RB_BIT		29

`endif

// ==== rtl/regCorePkg.sv ====
//********************
// Register id and write request types shared by the register subsystem
//********************
`include "regCore_cfg.svh"

package regCorePkg;

	// 0-31 general, 32-39 other bank, 40-44 control, 126 IMM, 127 ZZR
	typedef logic [6:0] regId_t;

	// General register write, number is R0..R31 as seen through SR.RB
	typedef struct packed {
		logic						valid;
		logic [4:0]					num;
		logic [`REG_WIDTH-1:0]		value;
	} gprWrite_t;

	// Control register write, any control id or the inactive bank
	typedef struct packed {
		logic						valid;
		regId_t						id;
		logic [`REG_WIDTH-1:0]		value;
	} ctlWrite_t;

endpackage

// ==== rtl/writeArbiter.sv ====
//********************
// Two-requester write arbiter, requester 0 first, one held entry
// Instantiated once per write port with that port's request struct
//********************
`timescale 1ns/1ps

module writeArbiter #(
	parameter type payload_t = regCorePkg::gprWrite_t
) (
	input  logic		clock,
	input  logic		reset,
	input  payload_t	req0,
	input  payload_t	req1,
	output payload_t	commit,
	output logic		busy
);

payload_t	holdSlot;
logic		holdFull;
logic		loadSlot;
logic		drainSlot;

// Requester 1 waits when it loses to req0 or to a held entry
assign loadSlot = req1.valid && (req0.valid || holdFull);
assign drainSlot = holdFull && !req0.valid;

always_comb
begin
	commit = req1;						// Carries valid low when idle
	if (req0.valid)
		commit = req0;
	else if (holdFull)
		commit = holdSlot;
end

always_ff @(posedge clock)
begin
	if (reset)
		holdFull <= 1'b0;
	else if (loadSlot)
		holdFull <= 1'b1;
	else if (drainSlot)
		holdFull <= 1'b0;
end

always_ff @(posedge clock)
begin
	if (loadSlot)
		holdSlot <= req1;
end

assign busy = holdFull;

endmodule

// ==== rtl/gprBank.sv ====
//********************
// Operand register storage with banked R0..R7 and the control registers
// Three general read ports and one control read port, all with write bypass
//********************
`timescale 1ns/1ps
`include "regCore_cfg.svh"

module gprBank (
	input  logic							clock,
	input  logic							reset,

	input  regCorePkg::regId_t				regIdRm,
	input  regCorePkg::regId_t				regIdRn,
	input  regCorePkg::regId_t				regIdRi,
	input  regCorePkg::regId_t				regIdCm,
	input  logic [32:0]						idImm,

	input  regCorePkg::gprWrite_t			gprCommit,
	input  regCorePkg::ctlWrite_t			ctlCommit,

	output logic [`REG_WIDTH-1:0]			regValRm,
	output logic [`REG_WIDTH-1:0]			regValRn,
	output logic [`REG_WIDTH-1:0]			regValRi,
	output logic [`REG_WIDTH-1:0]			regValCm,

	output logic [`REG_WIDTH-1:0]			sr,
	output logic [`REG_WIDTH-1:0]			ssr,
	output logic [`REG_WIDTH-1:0]			vbr
);

logic [`REG_WIDTH-1:0]	bankLo [0:1][0:7];		// Physical banks of R0..R7
logic [`REG_WIDTH-1:0]	gprHi [8:31];			// Unbanked R8..R31

logic [`REG_WIDTH-1:0]	regSr;
logic [`REG_WIDTH-1:0]	regVbr;
logic [`REG_WIDTH-1:0]	regGbr;
logic [`REG_WIDTH-1:0]	regSpc;
logic [`REG_WIDTH-1:0]	regSsr;

logic					rb;						// Active bank for ids 0..7
logic [`REG_WIDTH-1:0]	immExt;

assign rb = regSr[`SR_RB_BIT];
assign immExt = {{(`REG_WIDTH-33){idImm[32]}}, idImm};

assign sr = regSr;
assign ssr = regSsr;
assign vbr = regVbr;

function automatic logic isBankB(input regCorePkg::regId_t id);
	return (id >= `REG_ID_BANKB) && (id < (`REG_ID_BANKB + 7'd8));
endfunction

// General port decode, committing write overrides the stored value
function automatic logic [`REG_WIDTH-1:0] readGpr(input regCorePkg::regId_t id);
	logic [`REG_WIDTH-1:0] val;
	val = '0;
	if (id < 7'd8)
		val = bankLo[rb][id[2:0]];
	else if (id < `REG_ID_BANKB)
		val = gprHi[id[4:0]];
	else if (id == `REG_ID_IMM)
		val = immExt;
	if (gprCommit.valid && (id == {2'b00, gprCommit.num}))
		val = gprCommit.value;						// Bypass
	return val;
endfunction

// Control port decode; ZZR and unmapped ids fall through to zero
function automatic logic [`REG_WIDTH-1:0] readCtl(input regCorePkg::regId_t id);
	logic [`REG_WIDTH-1:0] val;
	val = '0;
	if (isBankB(id))
		val = bankLo[!rb][id[2:0]];
	else
	begin
		case (id)
			`REG_ID_SR:		val = regSr;
			`REG_ID_VBR:	val = regVbr;
			`REG_ID_GBR:	val = regGbr;
			`REG_ID_SPC:	val = regSpc;
			`REG_ID_SSR:	val = regSsr;
			default:		val = '0;
		endcase
	end
	if (ctlCommit.valid && (id == ctlCommit.id))
		val = ctlCommit.value;						// Bypass
	return val;
endfunction

always_comb
begin
	regValRm = readGpr(regIdRm);
	regValRn = readGpr(regIdRn);
	regValRi = readGpr(regIdRi);
	regValCm = readCtl(regIdCm);
end

// Both ports map through the SR held before this edge
always_ff @(posedge clock)
begin
	if (reset)
	begin
		for (int b = 0; b < 2; b++)
		begin
			for (int i = 0; i < 8; i++)
			begin
				bankLo[b][i] <= '0;
			end
		end
		for (int i = 8; i < 32; i++)
		begin
			gprHi[i] <= '0;
		end
		regSr <= '0;
		regVbr <= '0;
		regGbr <= '0;
		regSpc <= '0;
		regSsr <= '0;
	end
	else
	begin
		if (gprCommit.valid)
		begin
			if (gprCommit.num < 5'd8)
				bankLo[rb][gprCommit.num[2:0]] <= gprCommit.value;
			else
				gprHi[gprCommit.num] <= gprCommit.value;
		end

		if (ctlCommit.valid)
		begin
			if (isBankB(ctlCommit.id))
				bankLo[!rb][ctlCommit.id[2:0]] <= ctlCommit.value;	// Other bank
			else
			begin
				case (ctlCommit.id)
					`REG_ID_SR:		regSr <= ctlCommit.value;
					`REG_ID_VBR:	regVbr <= ctlCommit.value;
					`REG_ID_GBR:	regGbr <= ctlCommit.value;
					`REG_ID_SPC:	regSpc <= ctlCommit.value;
					`REG_ID_SSR:	regSsr <= ctlCommit.value;
					default:		;
				endcase
			end
		end
	end
end

endmodule

// ==== rtl/trapSequencer.sv ====
//********************
// Trap entry and return sequencing through the control write port
// Saves SR and trap PC to SSR/SPC, flips SR.RB, restores SR on return
//********************
`timescale 1ns/1ps
`include "regCore_cfg.svh"

module trapSequencer (
	input  logic						clock,
	input  logic						reset,
	input  logic						trapReq,
	input  logic						rteReq,
	input  logic [`REG_WIDTH-1:0]		trapPc,
	input  logic [`REG_WIDTH-1:0]		sr,
	input  logic [`REG_WIDTH-1:0]		ssr,
	output regCorePkg::ctlWrite_t		seqWrite,
	output logic						trapBusy
);

typedef enum logic [2:0] {
	idle,
	saveSr,
	savePc,
	setSr,
	restore
} seqState_t;

seqState_t				state;
logic [`REG_WIDTH-1:0]	savedSr;		// Snapshot at trap accept
logic [`REG_WIDTH-1:0]	savedPc;

always_ff @(posedge clock)
begin
	if (reset)
		state <= idle;
	else
	begin
		case (state)
			idle:
			begin
				if (trapReq)
					state <= saveSr;
				else if (rteReq)
					state <= restore;
			end
			saveSr:		state <= savePc;
			savePc:		state <= setSr;
			default:	state <= idle;	// setSr and restore end here
		endcase
	end
end

always_ff @(posedge clock)
begin
	if ((state == idle) && trapReq)
	begin
		savedSr <= sr;
		savedPc <= trapPc;
	end
end

always_comb
begin
	seqWrite = '0;
	case (state)
		saveSr:
		begin
			seqWrite.valid = 1'b1;
			seqWrite.id = `REG_ID_SSR;
			seqWrite.value = savedSr;
		end
		savePc:
		begin
			seqWrite.valid = 1'b1;
			seqWrite.id = `REG_ID_SPC;
			seqWrite.value = savedPc;
		end
		setSr:
		begin
			seqWrite.valid = 1'b1;
			seqWrite.id = `REG_ID_SR;
			seqWrite.value = savedSr;
			seqWrite.value[`SR_RB_BIT] = !savedSr[`SR_RB_BIT];	// Swap banks
		end
		restore:
		begin
			seqWrite.valid = 1'b1;
			seqWrite.id = `REG_ID_SR;
			seqWrite.value = ssr;		// Live SSR
		end
		default:	;
	endcase
end

assign trapBusy = (state != idle);

endmodule

// ==== rtl/regSubsystem.sv ====
//********************
// Register subsystem top with storage, write arbiters and trap sequencer
//********************
`timescale 1ns/1ps
`include "regCore_cfg.svh"

module regSubsystem (
	input  logic						clock,
	input  logic						reset,

	input  regCorePkg::regId_t			regIdRm,
	input  regCorePkg::regId_t			regIdRn,
	input  regCorePkg::regId_t			regIdRi,
	input  regCorePkg::regId_t			regIdCm,
	input  logic [32:0]					idImm,

	input  regCorePkg::gprWrite_t		aluWrite,
	input  regCorePkg::gprWrite_t		loadWrite,
	input  regCorePkg::ctlWrite_t		ctlWrite,

	input  logic						trapReq,
	input  logic						rteReq,
	input  logic [`REG_WIDTH-1:0]		trapPc,

	output logic [`REG_WIDTH-1:0]		regValRm,
	output logic [`REG_WIDTH-1:0]		regValRn,
	output logic [`REG_WIDTH-1:0]		regValRi,
	output logic [`REG_WIDTH-1:0]		regValCm,
	output logic [`REG_WIDTH-1:0]		sr,
	output logic [`REG_WIDTH-1:0]		vbr,

	output logic						gprBusy,
	output logic						ctlBusy,
	output logic						trapBusy
);

regCorePkg::gprWrite_t		gprCommit;
regCorePkg::ctlWrite_t		ctlCommit;
regCorePkg::ctlWrite_t		seqWrite;
logic [`REG_WIDTH-1:0]		ssr;

// Load return has priority over ALU writeback
writeArbiter #(
	.payload_t	(regCorePkg::gprWrite_t)
) gprArb (
	.clock		(clock),
	.reset		(reset),
	.req0		(loadWrite),
	.req1		(aluWrite),
	.commit		(gprCommit),
	.busy		(gprBusy)
);

// Trap sequencer has priority over external moves
writeArbiter #(
	.payload_t	(regCorePkg::ctlWrite_t)
) ctlArb (
	.clock		(clock),
	.reset		(reset),
	.req0		(seqWrite),
	.req1		(ctlWrite),
	.commit		(ctlCommit),
	.busy		(ctlBusy)
);

gprBank bank0 (
	.clock		(clock),
	.reset		(reset),
	.regIdRm	(regIdRm),
	.regIdRn	(regIdRn),
	.regIdRi	(regIdRi),
	.regIdCm	(regIdCm),
	.idImm		(idImm),
	.gprCommit	(gprCommit),
	.ctlCommit	(ctlCommit),
	.regValRm	(regValRm),
	.regValRn	(regValRn),
	.regValRi	(regValRi),
	.regValCm	(regValCm),
	.sr			(sr),
	.ssr		(ssr),
	.vbr		(vbr)
);

trapSequencer seq0 (
	.clock		(clock),
	.reset		(reset),
	.trapReq	(trapReq),
	.rteReq		(rteReq),
	.trapPc		(trapPc),
	.sr			(sr),
	.ssr		(ssr),
	.seqWrite	(seqWrite),
	.trapBusy	(trapBusy)
);

endmodule

// ==== sim/regSubsystem_props.sv ====
//********************
// Protocol assertions bound to the register subsystem top level
//********************
`timescale 1ns/1ps

module regSubsystemProps (
	input  logic						clock,
	input  logic						reset,
	input  regCorePkg::gprWrite_t		aluWrite,
	input  regCorePkg::ctlWrite_t		ctlWrite,
	input  logic						trapReq,
	input  logic						gprBusy,
	input  logic						ctlBusy,
	input  logic						trapBusy
);

// Requester 1 must wait while the hold slot is full
aluWhileBusy: assert property (@(posedge clock) disable iff (reset)
	!(aluWrite.valid && gprBusy))
	else $error("ALU write while gprBusy");

ctlWhileBusy: assert property (@(posedge clock) disable iff (reset)
	!(ctlWrite.valid && ctlBusy))
	else $error("Control write while ctlBusy");

trapWhileBusy: assert property (@(posedge clock) disable iff (reset)
	!(trapReq && trapBusy))
	else $error("Trap pulse while trapBusy");

busyAfterReset: assert property (@(posedge clock)
	$fell(reset) |-> (!gprBusy && !ctlBusy && !trapBusy))
	else $error("Busy output high after reset");

endmodule

bind regSubsystem regSubsystemProps props0 (.*);

// ==== sim/regSubsystemTb.sv ====
//********************
// Self-checking testbench for the register subsystem with a cycle model
// Runs directed phases then a long random mix, stimulus from an LFSR
//********************
`timescale 1ns/1ps
`include "regCore_cfg.svh"

module regSubsystemTb;

localparam int WB_CYCLES = 40;
localparam int BYP_CYCLES = 60;
localparam int COL_CYCLES = 60;
localparam int CTL_CYCLES = 60;
localparam int TRAP_CYCLES = 120;
localparam int MIX_CYCLES = 2000;
localparam int TOTAL_CYCLES = 16 + WB_CYCLES + BYP_CYCLES + COL_CYCLES + CTL_CYCLES
	+ TRAP_CYCLES + MIX_CYCLES;

logic clock;
logic reset;
regCorePkg::regId_t regIdRm, regIdRn, regIdRi, regIdCm;
logic [32:0] idImm;
regCorePkg::gprWrite_t aluWrite, loadWrite;
regCorePkg::ctlWrite_t ctlWrite;
logic trapReq, rteReq;
logic [63:0] trapPc;
logic [63:0] regValRm, regValRn, regValRi, regValCm, sr, vbr;
logic gprBusy, ctlBusy, trapBusy;

logic [31:0] lfsr = 32'hd59c;

// Model of the register image, both hold slots and the sequencer
logic [63:0] mBank [0:1][0:7];
logic [63:0] mHi [8:31];
logic [63:0] mSr, mVbr, mGbr, mSpc, mSsr;
logic gHeld, cHeld;
regCorePkg::gprWrite_t gSlot;
regCorePkg::ctlWrite_t cSlot;
int mState;									// 0 idle, 1-3 trap, 4 return
logic [63:0] mSavedSr, mSavedPc;

regSubsystem dut0 (.*);

initial
begin
	clock = 1'b0;
	forever #20 clock = ~clock;
end

function automatic logic [63:0] randBits(input int n);
	logic [63:0] r;
	r = '0;
	for (int i = 0; i < n; i++)
	begin
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		r = {r[62:0], lfsr[0]};
	end
	return r;
endfunction

function automatic regCorePkg::regId_t randGprId();
	logic [63:0] r;
	r = randBits(3);
	if (r[2:0] == 3'd5)
		return `REG_ID_IMM;
	if (r[2:0] == 3'd6)
		return `REG_ID_ZZR;
	r = randBits(7);
	if (r[2:0] == 3'd7)
		return r[6:0];							// Mostly unmapped, reads zero
	return {2'b00, r[6:2]};
endfunction

function automatic regCorePkg::regId_t randCtlId();
	logic [63:0] r;
	r = randBits(4);
	if (r[3] == 1'b0)
		return `REG_ID_BANKB + {4'd0, r[2:0]};
	return `REG_ID_SR + {4'd0, r[2:0]};			// 45..47 unmapped
endfunction

function automatic regCorePkg::gprWrite_t gprWinner();
	if (loadWrite.valid)
		return loadWrite;
	if (gHeld)
		return gSlot;
	return aluWrite;
endfunction

function automatic regCorePkg::ctlWrite_t seqOutput();
	regCorePkg::ctlWrite_t w;
	w = '0;
	w.valid = (mState != 0);
	case (mState)
		1:
		begin
			w.id = `REG_ID_SSR;
			w.value = mSavedSr;
		end
		2:
		begin
			w.id = `REG_ID_SPC;
			w.value = mSavedPc;
		end
		3:
		begin
			w.id = `REG_ID_SR;
			w.value = mSavedSr ^ (64'd1 << `SR_RB_BIT);
		end
		4:
		begin
			w.id = `REG_ID_SR;
			w.value = mSsr;
		end
		default:	;
	endcase
	return w;
endfunction

function automatic regCorePkg::ctlWrite_t ctlWinner();
	regCorePkg::ctlWrite_t s;
	s = seqOutput();
	if (s.valid)
		return s;
	if (cHeld)
		return cSlot;
	return ctlWrite;
endfunction

function automatic logic [63:0] expectGpr(input regCorePkg::regId_t id,
	input regCorePkg::gprWrite_t w);
	logic rb;
	logic [63:0] v;
	rb = mSr[`SR_RB_BIT];
	v = '0;
	if (id < 7'd8)
		v = mBank[rb][id[2:0]];
	else if (id < 7'd32)
		v = mHi[id[4:0]];
	else if (id == `REG_ID_IMM)
		v = {{31{idImm[32]}}, idImm};
	if (w.valid && (id == {2'b00, w.num}))
		v = w.value;							// Committing value wins
	return v;
endfunction

function automatic logic [63:0] expectCtl(input regCorePkg::regId_t id,
	input regCorePkg::ctlWrite_t w);
	logic [63:0] v;
	v = '0;
	if ((id >= 7'd32) && (id < 7'd40))
		v = mBank[~mSr[`SR_RB_BIT]][id[2:0]];
	else if (id == `REG_ID_SR)
		v = mSr;
	else if (id == `REG_ID_VBR)
		v = mVbr;
	else if (id == `REG_ID_GBR)
		v = mGbr;
	else if (id == `REG_ID_SPC)
		v = mSpc;
	else if (id == `REG_ID_SSR)
		v = mSsr;
	if (w.valid && (id == w.id))
		v = w.value;
	return v;
endfunction

task automatic checkValue(input string test, input string port, input logic [63:0] expected,
	input logic [63:0] actual);
	assert (expected === actual)
	else
	begin
		$display("ERROR test %s port %s expected %h actual %h", test, port, expected, actual);
		$display("Something failed");
		$fatal(1);
	end
endtask

task automatic checkOutputs(input string test);
	regCorePkg::gprWrite_t g;
	regCorePkg::ctlWrite_t c;
	g = gprWinner();
	c = ctlWinner();
	checkValue(test, "Rm", expectGpr(regIdRm, g), regValRm);
	checkValue(test, "Rn", expectGpr(regIdRn, g), regValRn);
	checkValue(test, "Ri", expectGpr(regIdRi, g), regValRi);
	checkValue(test, "Cm", expectCtl(regIdCm, c), regValCm);
	checkValue(test, "sr", mSr, sr);
	checkValue(test, "vbr", mVbr, vbr);
	checkValue(test, "gprBusy", {63'd0, gHeld}, {63'd0, gprBusy});
	checkValue(test, "ctlBusy", {63'd0, cHeld}, {63'd0, ctlBusy});
	checkValue(test, "trapBusy", {63'd0, mState != 0}, {63'd0, trapBusy});
endtask

// Advances the model across the coming clock edge
task automatic updateModel();
	regCorePkg::gprWrite_t g;
	regCorePkg::ctlWrite_t c;
	regCorePkg::ctlWrite_t s;
	logic rb;
	logic [63:0] srOld;
	g = gprWinner();
	c = ctlWinner();
	s = seqOutput();
	rb = mSr[`SR_RB_BIT];
	srOld = mSr;
	if (g.valid)
	begin
		if (g.num < 5'd8)
			mBank[rb][g.num[2:0]] = g.value;
		else
			mHi[g.num] = g.value;
	end
	if (c.valid)
	begin
		if ((c.id >= 7'd32) && (c.id < 7'd40))
			mBank[~rb][c.id[2:0]] = c.value;
		else if (c.id == `REG_ID_SR)
			mSr = c.value;
		else if (c.id == `REG_ID_VBR)
			mVbr = c.value;
		else if (c.id == `REG_ID_GBR)
			mGbr = c.value;
		else if (c.id == `REG_ID_SPC)
			mSpc = c.value;
		else if (c.id == `REG_ID_SSR)
			mSsr = c.value;
	end
	if (aluWrite.valid && (loadWrite.valid || gHeld))
	begin
		gHeld = 1'b1;
		gSlot = aluWrite;
	end
	else if (gHeld && !loadWrite.valid)
		gHeld = 1'b0;
	if (ctlWrite.valid && (s.valid || cHeld))
	begin
		cHeld = 1'b1;
		cSlot = ctlWrite;
	end
	else if (cHeld && !s.valid)
		cHeld = 1'b0;
	case (mState)
		0:
		begin
			if (trapReq)
			begin
				mState = 1;
				mSavedSr = srOld;
				mSavedPc = trapPc;
			end
			else if (rteReq)
				mState = 4;
		end
		1:			mState = 2;
		2:			mState = 3;
		default:	mState = 0;
	endcase
endtask

// Modes: 0 writeback, 1 bypass, 2 collision, 3 control, 4 trap, 5 mix
task automatic driveInputs(input int mode, input int step);
	regCorePkg::gprWrite_t a, l;
	regCorePkg::ctlWrite_t c;
	regCorePkg::regId_t rm, rn, ri, cm;
	logic tr, rt;
	logic [63:0] r;
	a = '0;
	l = '0;
	c = '0;
	tr = 1'b0;
	rt = 1'b0;
	rm = randGprId();
	rn = randGprId();
	ri = randGprId();
	cm = randCtlId();
	r = randBits(5);
	a.num = r[4:0];
	a.value = randBits(64);
	r = randBits(5);
	l.num = r[4:0];
	l.value = randBits(64);
	c.id = randCtlId();
	c.value = randBits(64);
	r = randBits(1);
	case (mode)
		0:
		begin
			a.valid = (step < 32);
			a.num = step[4:0];
		end
		1:
		begin
			a.valid = !gHeld;
			rm = {2'b00, a.num};
			c.valid = !cHeld && (c.id != `REG_ID_SR);
			cm = c.id;
		end
		2:
		begin
			l.valid = r[0];
			a.valid = !gHeld;
			rm = {2'b00, l.num};
			rn = gHeld ? {2'b00, gSlot.num} : {2'b00, a.num};	// Held entry commits now
		end
		3:
		begin
			c.valid = !cHeld;
			if (c.id >= `REG_ID_SR)
				c.id = r[0] ? `REG_ID_VBR : `REG_ID_GBR;
			rm = {4'd0, a.num[2:0]};
		end
		4:
		begin
			tr = ((step % 10) == 0) && (mState == 0);
			rt = ((step % 10) == 5) && (mState == 0);
			c.valid = r[0] && !cHeld && (c.id < `REG_ID_SR);
			if ((step % 10) == 8)
			begin
				c.valid = !cHeld;
				c.id = `REG_ID_SR;					// Random SR before the next trap
			end
			rm = {4'd0, a.num[2:0]};
		end
		default:
		begin
			l.valid = r[0];
			r = randBits(2);
			a.valid = r[0] && !gHeld;
			c.valid = r[1] && !cHeld;
			r = randBits(5);
			tr = (r[3:0] == 4'd0) && (mState == 0);
			rt = !tr && (r[4:1] == 4'd15) && (mState == 0);
		end
	endcase
	r = randBits(33);
	aluWrite <= a;
	loadWrite <= l;
	ctlWrite <= c;
	regIdRm <= rm;
	regIdRn <= rn;
	regIdRi <= ri;
	regIdCm <= cm;
	idImm <= r[32:0];
	trapReq <= tr;
	rteReq <= rt;
	trapPc <= randBits(64);
endtask

task automatic runPhase(input string test, input int mode, input int cycles);
	for (int step = 0; step < cycles; step++)
	begin
		driveInputs(mode, step);
		@(negedge clock);
		checkOutputs(test);
		updateModel();
		@(posedge clock);
	end
endtask

initial
begin
	#(TOTAL_CYCLES * 40 + 4000);
	$display("Timeout, the run did not finish in the expected time");
	$display("Something failed");
	$fatal(1);
end

initial
begin
	reset = 1'b1;
	regIdRm = '0;
	regIdRn = '0;
	regIdRi = '0;
	regIdCm = '0;
	idImm = '0;
	aluWrite = '0;
	loadWrite = '0;
	ctlWrite = '0;
	trapReq = 1'b0;
	rteReq = 1'b0;
	trapPc = '0;
	for (int b = 0; b < 2; b++)
	begin
		for (int i = 0; i < 8; i++)
		begin
			mBank[b][i] = '0;
		end
	end
	for (int i = 8; i < 32; i++)
	begin
		mHi[i] = '0;
	end
	mSr = '0;
	mVbr = '0;
	mGbr = '0;
	mSpc = '0;
	mSsr = '0;
	gHeld = 1'b0;
	cHeld = 1'b0;
	gSlot = '0;
	cSlot = '0;
	mState = 0;
	mSavedSr = '0;
	mSavedPc = '0;
	repeat (16) @(posedge clock);
	reset <= 1'b0;
	runPhase("writeReadBack", 0, WB_CYCLES);
	runPhase("bypass", 1, BYP_CYCLES);
	runPhase("writeCollision", 2, COL_CYCLES);
	runPhase("controlBank", 3, CTL_CYCLES);
	runPhase("trapReturn", 4, TRAP_CYCLES);
	runPhase("randomMix", 5, MIX_CYCLES);
	$display("Everything OK");
	$finish;
end

endmodule

// ==== compile.f ====
+incdir+rtl
rtl/regCorePkg.sv
rtl/writeArbiter.sv
rtl/gprBank.sv
rtl/trapSequencer.sv
rtl/regSubsystem.sv
sim/regSubsystem_props.sv
sim/regSubsystemTb.sv

// ==== Makefile ====
# Verilator build and run of the register subsystem testbench

VERILATOR ?= verilator
TOP ?= regSubsystemTb
FILELIST ?= compile.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing
PASS_TEXT ?= Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
